//--- source/sdSpiPkg.sv
// encodings and widths shared by the SD-card SPI host blocks
// referenced by scoped name from each module that needs them
package sdSpiPkg;

	// bus opcode driven by the master
	typedef enum logic [1:0] {
		opNone  = 2'd0,
		opRead  = 2'd1,
		opWrite = 2'd2
	} mmioOp;

	// answer on mmioOk
	typedef enum logic [1:0] {
		respReady = 2'd0,
		respOk    = 2'd1,
		respHold  = 2'd2
	} mmioResp;

	// register select, address bits 3:2
	typedef enum logic [1:0] {
		regCtrl  = 2'd0,
		regData  = 2'd1,
		regQueue = 2'd2
	} regOffset;

	// bit engine phases
	typedef enum logic [1:0] {
		engIdle = 2'd0,
		engLow  = 2'd1,
		engHigh = 2'd2
	} engineState;

	// ctrl register fields
	localparam int ctrlCsBit    = 0;
	localparam int ctrlBusyBit  = 1;
	localparam int ctrlBurstBit = 5;
	localparam int ctrlDivLsb   = 24;

	localparam int dataWidth  = 64;
	localparam int byteWidth  = 8;
	localparam int queueBytes = 8;

endpackage

//--- source/spiXferIf.sv
// byte-transfer handshake between the register block, burst sequencer and bit engine
// requester pulses start with txByte, engine answers with busy, done and rxByte
`timescale 1ns/1ps

interface spiXferIf;

	// requester side
	logic                           start;
	logic [sdSpiPkg::byteWidth-1:0] txByte;

	// engine side
	logic                           busy;
	logic                           done;
	logic [sdSpiPkg::byteWidth-1:0] rxByte;

	// register block, also the sequencer toward the engine
	modport regs (output start, output txByte, input busy, input done, input rxByte);

	// sequencer facing the register block
	modport seq (input start, input txByte, output busy, output done, output rxByte);

	// bit engine
	modport eng (input start, input txByte, output busy, output done, output rxByte);

endinterface

//--- source/mmioRegs.sv
// MMIO register window: ctrl, single-byte data and burst queue registers
// answers READY/OK/HOLD two cycles after a request and launches transfers
`timescale 1ns/1ps

module mmioRegs (
	input  logic                           clock,
	input  logic                           rstN,
	input  logic [sdSpiPkg::dataWidth-1:0] mmioInData,
	input  logic [3:0]                     mmioAddr,
	input  sdSpiPkg::mmioOp                mmioOpm,
	input  logic                           burstBusy,
	input  logic [sdSpiPkg::dataWidth-1:0] recvQueue,
	output logic [sdSpiPkg::dataWidth-1:0] mmioOutData,
	output sdSpiPkg::mmioResp              mmioOk,
	output logic [sdSpiPkg::dataWidth-1:0] sendQueue,
	output logic                           burstStart,
	output logic                           csAssert,
	output logic [sdSpiPkg::byteWidth-1:0] divider,
	spiXferIf.regs                         xfer
);
	localparam int ctrlWidth = 32;

	sdSpiPkg::mmioOp                opQ;
	sdSpiPkg::regOffset             offQ;
	logic [sdSpiPkg::dataWidth-1:0] dataQ;
	logic [ctrlWidth-1:0]           ctrlReg;
	logic [ctrlWidth-1:0]           ctrlView;
	logic [ctrlWidth-1:0]           ctrlWrVal;
	logic [sdSpiPkg::byteWidth-1:0] dataTx;
	logic [sdSpiPkg::byteWidth-1:0] rxHold;
	logic                           startQ;
	logic                           reqLatch;
	logic                           busyAll;
	logic                           ctrlWr;
	logic                           dataWr;
	logic                           queueWr;
	sdSpiPkg::mmioResp              respNext;
	logic [sdSpiPkg::dataWidth-1:0] outNext;

	// pending launches count as busy so a poll never sees a gap
	assign busyAll = xfer.busy || burstBusy || startQ || burstStart;

	assign csAssert    = ctrlReg[sdSpiPkg::ctrlCsBit];
	assign divider     = ctrlReg[sdSpiPkg::ctrlDivLsb +: sdSpiPkg::byteWidth];
	assign xfer.start  = startQ;
	assign xfer.txByte = dataTx;

	// busy flag replaces bit 1 on read
	always_comb
	begin
		ctrlView = ctrlReg;
		ctrlView[sdSpiPkg::ctrlBusyBit] = busyAll;
	end

	// start bits are strobes, never stored
	always_comb
	begin
		ctrlWrVal = dataQ[ctrlWidth-1:0];
		ctrlWrVal[sdSpiPkg::ctrlBusyBit] = 1'b0;
		ctrlWrVal[sdSpiPkg::ctrlBurstBit] = 1'b0;
	end

	// decode of the registered request
	always_comb
	begin
		respNext = sdSpiPkg::respReady;
		outNext  = '0;
		ctrlWr   = 1'b0;
		dataWr   = 1'b0;
		queueWr  = 1'b0;
		// latched cycle holds the stale copy of the request just answered
		if (opQ != sdSpiPkg::opNone && !reqLatch)
		begin
			case (offQ)
				sdSpiPkg::regCtrl:
				begin
					if (opQ == sdSpiPkg::opRead)
					begin
						outNext  = {{(sdSpiPkg::dataWidth - ctrlWidth){1'b0}}, ctrlView};
						respNext = sdSpiPkg::respOk;
					end
					else if (busyAll)
						respNext = sdSpiPkg::respHold;
					else
					begin
						ctrlWr   = 1'b1;
						respNext = sdSpiPkg::respOk;
					end
				end
				sdSpiPkg::regData:
				begin
					// exchange register is off limits mid-transfer
					if (busyAll)
						respNext = sdSpiPkg::respHold;
					else if (opQ == sdSpiPkg::opRead)
					begin
						outNext  = {{(sdSpiPkg::dataWidth - sdSpiPkg::byteWidth){1'b0}}, rxHold};
						respNext = sdSpiPkg::respOk;
					end
					else
					begin
						dataWr   = 1'b1;
						respNext = sdSpiPkg::respOk;
					end
				end
				sdSpiPkg::regQueue:
				begin
					if (opQ == sdSpiPkg::opRead)
						outNext = recvQueue;
					else
						queueWr = 1'b1;
					respNext = sdSpiPkg::respOk;
				end
				// unmapped offset reads zero
				default:
					respNext = sdSpiPkg::respOk;
			endcase
		end
	end

	// bus side and control state
	always_ff @(posedge clock)
	begin
		if (!rstN)
		begin
			opQ        <= sdSpiPkg::opNone;
			mmioOk     <= sdSpiPkg::respReady;
			reqLatch   <= 1'b0;
			ctrlReg    <= '0;
			startQ     <= 1'b0;
			burstStart <= 1'b0;
		end
		else
		begin
			opQ      <= mmioOpm;
			mmioOk   <= respNext;
			reqLatch <= (respNext == sdSpiPkg::respOk);
			if (ctrlWr)
				ctrlReg <= ctrlWrVal;
			// single start wins over burst
			startQ     <= ctrlWr && dataQ[sdSpiPkg::ctrlBusyBit];
			burstStart <= ctrlWr && !dataQ[sdSpiPkg::ctrlBusyBit]
				&& dataQ[sdSpiPkg::ctrlBurstBit];
		end
	end

	// payload registers
	always_ff @(posedge clock)
	begin
		offQ        <= sdSpiPkg::regOffset'(mmioAddr[3:2]);
		dataQ       <= mmioInData;
		mmioOutData <= outNext;
		if (dataWr)
			dataTx <= dataQ[sdSpiPkg::byteWidth-1:0];
		if (queueWr)
			sendQueue <= dataQ;
		// done is masked during bursts, so this keeps the last single byte
		if (xfer.done)
			rxHold <= xfer.rxByte;
	end

	// engine must be free whenever a single exchange is launched
	startWhileBusy: assert property (@(posedge clock) disable iff (!rstN)
		xfer.start |-> !xfer.busy)
		else $error("single start raised while transfer busy");

endmodule

//--- source/burstSequencer.sv
// runs 8 back-to-back byte exchanges from the send queue into the receive queue
// passes single exchanges from the register block straight to the engine
`timescale 1ns/1ps

module burstSequencer (
	input  logic                           clock,
	input  logic                           rstN,
	input  logic                           burstStart,
	input  logic [sdSpiPkg::dataWidth-1:0] sendQueue,
	output logic                           burstBusy,
	output logic [sdSpiPkg::dataWidth-1:0] recvQueue,
	spiXferIf.seq                          up,
	spiXferIf.regs                         down
);
	localparam int cntWidth = $clog2(sdSpiPkg::queueBytes);

	logic                           active;
	logic                           issue;
	logic [cntWidth-1:0]            byteCnt;
	logic [sdSpiPkg::dataWidth-1:0] sendShift;
	logic                           lastByte;
	logic                           launch;
	logic                           byteDone;

	assign lastByte = (byteCnt == cntWidth'(sdSpiPkg::queueBytes - 1));
	assign launch   = burstStart && !active;
	assign byteDone = active && down.done;
	assign burstBusy = active;

	// burst owns the engine, otherwise pass through
	assign down.start  = active ? issue : up.start;
	assign down.txByte = active ? sendShift[sdSpiPkg::byteWidth-1:0] : up.txByte;
	assign up.busy     = down.busy || active;
	assign up.done     = down.done && !active;
	assign up.rxByte   = down.rxByte;

	always_ff @(posedge clock)
	begin
		if (!rstN)
		begin
			active  <= 1'b0;
			issue   <= 1'b0;
			byteCnt <= '0;
		end
		else
		begin
			issue <= 1'b0;
			if (launch)
			begin
				active  <= 1'b1;
				issue   <= 1'b1;
				byteCnt <= '0;
			end
			else if (byteDone)
			begin
				if (lastByte)
					active <= 1'b0;
				else
				begin
					// next byte one cycle after done, engine idle by then
					byteCnt <= byteCnt + 1'b1;
					issue   <= 1'b1;
				end
			end
		end
	end

	// low byte goes out first, received bytes enter at the top
	always_ff @(posedge clock)
	begin
		if (launch)
			sendShift <= sendQueue;
		else if (byteDone)
			sendShift <= {{sdSpiPkg::byteWidth{1'b1}},
				sendShift[sdSpiPkg::dataWidth-1:sdSpiPkg::byteWidth]};
		if (byteDone)
			recvQueue <= {down.rxByte, recvQueue[sdSpiPkg::dataWidth-1:sdSpiPkg::byteWidth]};
	end

	// register block only launches a burst when everything is idle
	burstOverlap: assert property (@(posedge clock) disable iff (!rstN)
		burstStart |-> !active && !down.busy)
		else $error("burst launched while a transfer is running");

endmodule

//--- source/spiBitEngine.sv
// mode 0 SPI byte engine: SCLK divider, MSB-first shift, registered pins
// MISO passes a two-flop synchronizer and is sampled with matching delay
`timescale 1ns/1ps

module spiBitEngine #(
	parameter int divWidth = 9
) (
	input  logic                           clock,
	input  logic                           rstN,
	input  logic [sdSpiPkg::byteWidth-1:0] divider,
	input  logic                           csAssert,
	input  logic                           miso,
	output logic                           sclk,
	output logic                           mosi,
	output logic                           csN,
	spiXferIf.eng                          xfer
);
	localparam int bitWidth = $clog2(sdSpiPkg::byteWidth);

	sdSpiPkg::engineState           state;
	logic [divWidth-1:0]            halfCnt;
	logic [divWidth-1:0]            halfLen;
	logic [bitWidth-1:0]            bitCnt;
	logic [sdSpiPkg::byteWidth-1:0] txShift;
	logic [sdSpiPkg::byteWidth-1:0] rxShift;
	logic                           misoMeta;
	logic                           misoSync;
	logic [1:0]                     sampleDly;
	logic                           halfEnd;
	logic                           riseNow;
	logic                           lastBit;
	logic                           busyNow;
	logic                           busyQ;

	// half period of div+1 clocks, needs one bit above the divider
	assign halfLen = divWidth'(divider) + divWidth'(1);
	assign halfEnd = (halfCnt == divWidth'(1));
	assign riseNow = (state == sdSpiPkg::engLow) && halfEnd;
	assign lastBit = (bitCnt == bitWidth'(sdSpiPkg::byteWidth - 1));

	// stays busy until the last delayed sample lands
	assign busyNow     = (state != sdSpiPkg::engIdle) || (sampleDly != 2'b00);
	assign xfer.busy   = busyNow;
	assign xfer.done   = busyQ && !busyNow;
	assign xfer.rxByte = rxShift;

	always_ff @(posedge clock)
	begin
		misoMeta <= miso;
		misoSync <= misoMeta;
	end

	always_ff @(posedge clock)
	begin
		if (!rstN)
		begin
			state     <= sdSpiPkg::engIdle;
			halfCnt   <= '0;
			bitCnt    <= '0;
			sclk      <= 1'b0;
			mosi      <= 1'b0;
			csN       <= 1'b1;
			sampleDly <= 2'b00;
			busyQ     <= 1'b0;
		end
		else
		begin
			busyQ <= busyNow;
			// rising edge strobe delayed by the synchronizer depth
			sampleDly <= {sampleDly[0], riseNow};
			case (state)
				sdSpiPkg::engIdle:
				begin
					// chip select only moves between bytes
					csN <= !csAssert;
					if (xfer.start)
					begin
						state   <= sdSpiPkg::engLow;
						halfCnt <= halfLen;
						bitCnt  <= '0;
						mosi    <= xfer.txByte[sdSpiPkg::byteWidth-1];
					end
				end
				sdSpiPkg::engLow:
				begin
					if (halfEnd)
					begin
						sclk    <= 1'b1;
						state   <= sdSpiPkg::engHigh;
						halfCnt <= halfLen;
					end
					else
						halfCnt <= halfCnt - 1'b1;
				end
				sdSpiPkg::engHigh:
				begin
					if (halfEnd)
					begin
						sclk <= 1'b0;
						if (lastBit)
							state <= sdSpiPkg::engIdle;
						else
						begin
							// next bit goes out on the falling edge
							bitCnt  <= bitCnt + 1'b1;
							mosi    <= txShift[sdSpiPkg::byteWidth-2];
							state   <= sdSpiPkg::engLow;
							halfCnt <= halfLen;
						end
					end
					else
						halfCnt <= halfCnt - 1'b1;
				end
				default:
					state <= sdSpiPkg::engIdle;
			endcase
		end
	end

	// shift registers
	always_ff @(posedge clock)
	begin
		if (state == sdSpiPkg::engIdle && xfer.start)
			txShift <= xfer.txByte;
		else if (state == sdSpiPkg::engHigh && halfEnd)
			txShift <= {txShift[sdSpiPkg::byteWidth-2:0], 1'b0};
		if (sampleDly[1])
			rxShift <= {rxShift[sdSpiPkg::byteWidth-2:0], misoSync};
	end

	sclkIdleLow: assert property (@(posedge clock) disable iff (!rstN)
		(state == sdSpiPkg::engIdle) |-> !sclk)
		else $error("sclk high while engine idle");

endmodule

//--- source/sdSpiHost.sv
// SD-card SPI host top level with plain MMIO and SPI pin ports
// divWidth sizes the SCLK half-period counter in the bit engine
`timescale 1ns/1ps

module sdSpiHost #(
	parameter int divWidth = 9
) (
	input  logic                           clock,
	input  logic                           rstN,
	input  logic [sdSpiPkg::dataWidth-1:0] mmioInData,
	input  logic [3:0]                     mmioAddr,
	input  sdSpiPkg::mmioOp                mmioOpm,
	input  logic                           miso,
	output logic [sdSpiPkg::dataWidth-1:0] mmioOutData,
	output sdSpiPkg::mmioResp              mmioOk,
	output logic                           sclk,
	output logic                           mosi,
	output logic                           csN
);
	logic                           burstBusy;
	logic                           burstStart;
	logic                           csAssert;
	logic [sdSpiPkg::byteWidth-1:0] divider;
	logic [sdSpiPkg::dataWidth-1:0] sendQueue;
	logic [sdSpiPkg::dataWidth-1:0] recvQueue;

	// register block to sequencer, sequencer to engine
	spiXferIf regXfer ();
	spiXferIf engXfer ();

	mmioRegs regBlock (
		.clock(clock), .rstN(rstN),
		.mmioInData(mmioInData), .mmioAddr(mmioAddr), .mmioOpm(mmioOpm),
		.burstBusy(burstBusy), .recvQueue(recvQueue),
		.mmioOutData(mmioOutData), .mmioOk(mmioOk),
		.sendQueue(sendQueue), .burstStart(burstStart),
		.csAssert(csAssert), .divider(divider),
		.xfer(regXfer)
	);

	burstSequencer sequencer (
		.clock(clock), .rstN(rstN),
		.burstStart(burstStart), .sendQueue(sendQueue),
		.burstBusy(burstBusy), .recvQueue(recvQueue),
		.up(regXfer), .down(engXfer)
	);

	spiBitEngine #(.divWidth(divWidth)) engine (
		.clock(clock), .rstN(rstN),
		.divider(divider), .csAssert(csAssert), .miso(miso),
		.sclk(sclk), .mosi(mosi), .csN(csN),
		.xfer(engXfer)
	);

endmodule

//--- test/sdSpiHostTb.sv
// testbench for the SD-card SPI host: MMIO bus driver, SPI slave model and checks
// stimulus and expected results come from test/sdSpiVectors.txt, run from the project root
`timescale 1ns/1ps

module sdSpiHostTb;

	localparam int busTimeout = 2000;
	localparam int pollLimit  = 300;
	localparam int waitLimit  = 50;

	logic                           clock;
	logic                           rstN;
	logic [sdSpiPkg::dataWidth-1:0] mmioInData;
	logic [3:0]                     mmioAddr;
	sdSpiPkg::mmioOp                mmioOpm;
	logic                           miso;
	logic [sdSpiPkg::dataWidth-1:0] mmioOutData;
	sdSpiPkg::mmioResp              mmioOk;
	logic                           sclk;
	logic                           mosi;
	logic                           csN;

	// slave model state
	logic [7:0]  capBytes [256];
	logic [7:0]  capShift = '0;
	int          riseCnt = 0;
	int          fallCnt = 0;
	int          outBase = 0;
	logic [63:0] retWord = '0;
	int          highRun = 0;
	int          lastHigh = 0;
	logic        burstWatch = 1'b0;
	int          csHighCnt = 0;

	int errors = 0;
	int timeouts = 0;
	int vecCount = 0;

	sdSpiHost #(.divWidth(9)) uut (
		.clock(clock), .rstN(rstN),
		.mmioInData(mmioInData), .mmioAddr(mmioAddr), .mmioOpm(mmioOpm),
		.miso(miso),
		.mmioOutData(mmioOutData), .mmioOk(mmioOk),
		.sclk(sclk), .mosi(mosi), .csN(csN)
	);

	always #5 clock = ~clock;

	// byte 0 of the return word goes first, MSB first inside each byte
	function automatic logic slaveBit(input logic [63:0] word, input int rel, input logic csHigh);
		int pos;
		pos = 8 * (rel / 8) + 7 - (rel % 8);
		if (csHigh || rel < 0 || rel > 63)
			return 1'b0;
		return word[6'(pos)];
	endfunction

	// ctrl word from the field layout: cs bit 0, single 1, burst 5, divider 31:24
	function automatic logic [63:0] ctrlValue(input logic [7:0] div, input logic cs,
		input logic single, input logic burst);
		logic [63:0] v;
		v = '0;
		v[sdSpiPkg::ctrlCsBit] = cs;
		v[sdSpiPkg::ctrlBusyBit] = single;
		v[sdSpiPkg::ctrlBurstBit] = burst;
		v[sdSpiPkg::ctrlDivLsb +: 8] = div;
		return v;
	endfunction

	// mosi is stable at the rising edge, one byte per 8 rises
	always @(posedge sclk)
	begin
		capShift <= {capShift[6:0], mosi};
		if (riseCnt % 8 == 7)
			capBytes[8'((riseCnt / 8) % 256)] <= {capShift[6:0], mosi};
		riseCnt <= riseCnt + 1;
	end

	// next bit appears after each falling edge
	always @(negedge sclk)
		fallCnt <= fallCnt + 1;

	assign miso = slaveBit(retWord, fallCnt - outBase, csN);

	// sclk high time in clock cycles, and chip select watch during bursts
	always @(negedge clock)
	begin
		if (sclk)
			highRun <= highRun + 1;
		else if (highRun != 0)
		begin
			lastHigh <= highRun;
			highRun  <= 0;
		end
		if (burstWatch && csN)
			csHighCnt <= csHighCnt + 1;
	end

	task automatic flagMismatch(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		$display("Fail %s: expected %h actual %h", name, expected, actual);
		errors++;
	endtask

	// request stays on the bus until OK, holds are counted
	task automatic busWrite(input logic [3:0] addr, input logic [63:0] data, output int holds);
		int waited;
		waited = 0;
		holds = 0;
		@(negedge clock);
		mmioOpm    = sdSpiPkg::opWrite;
		mmioAddr   = addr;
		mmioInData = data;
		do
		begin
			@(negedge clock);
			if (mmioOk == sdSpiPkg::respHold)
				holds++;
			waited++;
		end
		while (mmioOk != sdSpiPkg::respOk && waited < busTimeout);
		if (mmioOk != sdSpiPkg::respOk)
		begin
			$display("bus write to offset %h got no OK within %0d cycles", addr, busTimeout);
			timeouts++;
		end
		mmioOpm = sdSpiPkg::opNone;
	endtask

	task automatic busRead(input logic [3:0] addr, output logic [63:0] data);
		int waited;
		waited = 0;
		@(negedge clock);
		mmioOpm  = sdSpiPkg::opRead;
		mmioAddr = addr;
		do
		begin
			@(negedge clock);
			waited++;
		end
		while (mmioOk != sdSpiPkg::respOk && waited < busTimeout);
		if (mmioOk != sdSpiPkg::respOk)
		begin
			$display("bus read from offset %h got no OK within %0d cycles", addr, busTimeout);
			timeouts++;
		end
		// read data valid alongside OK
		data    = mmioOutData;
		mmioOpm = sdSpiPkg::opNone;
	endtask

	// poll ctrl until the busy flag drops
	task automatic waitIdle(input string name);
		logic [63:0] ctrl;
		int polls;
		polls = 0;
		do
		begin
			busRead(4'h0, ctrl);
			polls++;
		end
		while (ctrl[sdSpiPkg::ctrlBusyBit] && polls < pollLimit);
		if (ctrl[sdSpiPkg::ctrlBusyBit])
		begin
			$display("%s: busy flag still set after %0d polls", name, polls);
			timeouts++;
		end
	endtask

	task automatic waitCs(input logic level, input string name);
		int waited;
		waited = 0;
		while (csN != level && waited < waitLimit)
		begin
			@(negedge clock);
			waited++;
		end
		if (csN != level)
		begin
			$display("%s: csN did not reach %0d within %0d cycles", name, level, waitLimit);
			timeouts++;
		end
	endtask

	// point the slave at a fresh return word
	task automatic armSlave(input logic [63:0] ret, output int base);
		retWord = ret;
		outBase = fallCnt;
		base    = riseCnt / 8;
	endtask

	task automatic singleExchange(input int idx, input logic [7:0] div, input logic [63:0] tx,
		input logic [63:0] ret, input logic [63:0] expMosi, input logic [63:0] expRead);
		int holds;
		int base;
		logic [63:0] got;
		string name;
		name = $sformatf("vector %0d single", idx);
		busWrite(4'h4, tx, holds);
		armSlave(ret, base);
		busWrite(4'h0, ctrlValue(div, 1'b1, 1'b1, 1'b0), holds);
		waitIdle(name);
		if (riseCnt != (base + 1) * 8)
			flagMismatch({name, " sclk rises"}, 64'((base + 1) * 8), 64'(riseCnt));
		if (capBytes[8'(base % 256)] != expMosi[7:0])
			flagMismatch({name, " mosi byte"}, 64'(expMosi[7:0]), 64'(capBytes[8'(base % 256)]));
		busRead(4'h4, got);
		if (got != expRead)
			flagMismatch({name, " data read"}, expRead, got);
		if (lastHigh != int'(div) + 1)
			flagMismatch({name, " sclk high time"}, 64'(int'(div) + 1), 64'(lastHigh));
	endtask

	task automatic burstExchange(input int idx, input logic [7:0] div, input logic [63:0] tx,
		input logic [63:0] ret, input logic [63:0] expMosi, input logic [63:0] expRead);
		int holds;
		int base;
		int csBefore;
		logic [63:0] got;
		logic [63:0] seen;
		string name;
		name = $sformatf("vector %0d burst", idx);
		busWrite(4'h8, tx, holds);
		armSlave(ret, base);
		busWrite(4'h0, ctrlValue(div, 1'b1, 1'b0, 1'b1), holds);
		waitCs(1'b0, name);
		csBefore   = csHighCnt;
		burstWatch = 1'b1;
		waitIdle(name);
		burstWatch = 1'b0;
		if (csHighCnt != csBefore)
			flagMismatch({name, " cycles with csN high"}, 64'(0), 64'(csHighCnt - csBefore));
		if (riseCnt != (base + 8) * 8)
			flagMismatch({name, " sclk rises"}, 64'((base + 8) * 8), 64'(riseCnt));
		// first captured byte ends in the low byte
		seen = '0;
		for (int i = 0; i < 8; i++)
			seen = {capBytes[8'((base + i) % 256)], seen[63:8]};
		if (seen != expMosi)
			flagMismatch({name, " mosi bytes"}, expMosi, seen);
		busRead(4'h8, got);
		if (got != expRead)
			flagMismatch({name, " queue read"}, expRead, got);
		if (lastHigh != int'(div) + 1)
			flagMismatch({name, " sclk high time"}, 64'(int'(div) + 1), 64'(lastHigh));
	endtask

	// ctrl write issued mid-transfer, expRead is both the new ctrl and its readback
	task automatic busyCtrlWrite(input int idx, input logic [7:0] div, input logic [63:0] tx,
		input logic [63:0] ret, input logic [63:0] expMosi, input logic [63:0] expRead);
		int holds;
		int base;
		logic [63:0] got;
		string name;
		name = $sformatf("vector %0d write while busy", idx);
		busWrite(4'h4, tx, holds);
		armSlave(ret, base);
		busWrite(4'h0, ctrlValue(div, 1'b1, 1'b1, 1'b0), holds);
		busWrite(4'h0, expRead, holds);
		if (holds == 0)
		begin
			$display("%s: ctrl write was taken without a HOLD answer", name);
			errors++;
		end
		// the byte must be complete once the write is taken
		if (riseCnt != (base + 1) * 8)
			flagMismatch({name, " sclk rises at accept"}, 64'((base + 1) * 8), 64'(riseCnt));
		if (capBytes[8'(base % 256)] != expMosi[7:0])
			flagMismatch({name, " mosi byte"}, 64'(expMosi[7:0]), 64'(capBytes[8'(base % 256)]));
		busRead(4'h0, got);
		if (got != expRead)
			flagMismatch({name, " ctrl readback"}, expRead, got);
	endtask

	initial
	begin
		string line;
		int fd;
		int code;
		int fields;
		int kind;
		int holds;
		logic [7:0] div;
		logic [63:0] tx;
		logic [63:0] ret;
		logic [63:0] expMosi;
		logic [63:0] expRead;
		logic [63:0] got;

		clock      = 1'b0;
		rstN       = 1'b0;
		mmioInData = '0;
		mmioAddr   = '0;
		mmioOpm    = sdSpiPkg::opNone;
		repeat (4) @(negedge clock);
		rstN = 1'b1;

		// reset state
		if (csN != 1'b1)
			flagMismatch("reset csN", 64'(1), 64'(csN));
		if (sclk != 1'b0)
			flagMismatch("reset sclk", 64'(0), 64'(sclk));
		if (mosi != 1'b0)
			flagMismatch("reset mosi", 64'(0), 64'(mosi));
		if (mmioOk != sdSpiPkg::respReady)
			flagMismatch("reset mmioOk", 64'(sdSpiPkg::respReady), 64'(mmioOk));
		busRead(4'h0, got);
		if (got[sdSpiPkg::ctrlBusyBit] != 1'b0)
			flagMismatch("reset busy", 64'(0), 64'(got[sdSpiPkg::ctrlBusyBit]));
		if (got[sdSpiPkg::ctrlDivLsb +: 8] != 8'h00)
			flagMismatch("reset divider", 64'(0), 64'(got[sdSpiPkg::ctrlDivLsb +: 8]));

		// chip select at idle, both directions
		busWrite(4'h0, ctrlValue(8'h00, 1'b1, 1'b0, 1'b0), holds);
		waitCs(1'b0, "cs assert");
		busWrite(4'h0, ctrlValue(8'h00, 1'b0, 1'b0, 1'b0), holds);
		waitCs(1'b1, "cs release");

		fd = $fopen("test/sdSpiVectors.txt", "r");
		if (fd == 0)
		begin
			$display("cannot open test/sdSpiVectors.txt");
			errors++;
		end
		else
		begin
			while (!$feof(fd))
			begin
				line = "";
				code = $fgets(line, fd);
				// comment and blank lines do not parse to six fields
				fields = $sscanf(line, "%d %h %h %h %h %h", kind, div, tx, ret, expMosi, expRead);
				if (code > 0 && fields == 6)
				begin
					vecCount++;
					case (kind)
						0: singleExchange(vecCount, div, tx, ret, expMosi, expRead);
						1: burstExchange(vecCount, div, tx, ret, expMosi, expRead);
						2: busyCtrlWrite(vecCount, div, tx, ret, expMosi, expRead);
						default:
						begin
							$display("vector %0d has unknown kind %0d", vecCount, kind);
							errors++;
						end
					endcase
				end
			end
			$fclose(fd);
		end
		if (vecCount == 0)
		begin
			$display("no vectors were read");
			errors++;
		end

		$display("vectors %0d, check errors %0d, timeouts %0d", vecCount, errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

//--- test/sdSpiVectors.txt
# kind: 0 single exchange, 1 burst, 2 ctrl write while busy
# kind div tx ret expMosi expRead (hex, expRead is the ctrl value for kind 2)
0 00 00000000000000a5 000000000000003c 00000000000000a5 000000000000003c
0 03 000000000000005a 00000000000000c3 000000000000005a 00000000000000c3
0 01 00000000000000ff 0000000000000081 00000000000000ff 0000000000000081
1 01 0807060504030201 8877665544332211 0807060504030201 8877665544332211
1 00 f0e1d2c3b4a59687 0123456789abcdef f0e1d2c3b4a59687 0123456789abcdef
2 02 0000000000000096 0000000000000069 0000000000000096 0000000003000001
2 01 000000000000003e 00000000000000e3 000000000000003e 0000000005000000
0 02 0000000000000011 00000000000000ee 0000000000000011 00000000000000ee

//--- sdSpi.f
source/sdSpiPkg.sv
source/spiXferIf.sv
source/mmioRegs.sv
source/burstSequencer.sv
source/spiBitEngine.sv
source/sdSpiHost.sv
test/sdSpiHostTb.sv

//--- build.sh
#!/usr/bin/env bash
# compile and run the SD-card SPI host testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 \
	-f sdSpi.f --top-module sdSpiHostTb --Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "verilator compile failed"
	exit 1
fi

./obj_dir/VsdSpiHostTb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "RESULT: FAIL" "$LOG"; then
	echo "testbench reported failure, see $LOG"
	exit 1
fi

echo "simulation finished without failures"
exit 0
